// ==== common/lsu_pkg.sv ====
//////////////////////////////////////////////////
// shared widths, enums and exception codes of the LSU
// the beat struct depends on the bus width and lives in the stages
//////////////////////////////////////////////////

package lsu_pkg;

    // address generation mode of a beat
    typedef enum logic [1:0] {
        LSU_UNIT_STRIDE = 2'd0,
        LSU_STRIDED     = 2'd1,
        LSU_INDEXED     = 2'd2
    } lsu_stride_e;

    // element width
    typedef enum logic [1:0] {
        LSU_EEW_8  = 2'd0,
        LSU_EEW_16 = 2'd1,
        LSU_EEW_32 = 2'd2
    } lsu_eew_e;

    localparam int unsigned LSU_ID_W  = 3;
    localparam int unsigned LSU_EXC_W = 6;

    // access faults reported on a bus error
    localparam logic [LSU_EXC_W-1:0] EXC_LOAD_FAULT  = 6'd5;
    localparam logic [LSU_EXC_W-1:0] EXC_STORE_FAULT = 6'd7;

    // beat control bits apart from vl_part:
    // first, last, id, stride, eew, store, masked, vl_zero
    localparam int unsigned LSU_BEAT_FIX_W = 2 + LSU_ID_W + $bits(lsu_stride_e)
                                           + $bits(lsu_eew_e) + 2 + 1;

endpackage

// ==== common/lsu_mem_if.sv ====
//////////////////////////////////////////////////
// memory port of the LSU, valid/ready requests
// responses return in order and cannot be stalled
//////////////////////////////////////////////////

interface lsu_mem_if import lsu_pkg::*; #(
    parameter int unsigned VMEM_W = 32
) ();

    // request channel, addr is aligned to the bus word
    logic                req_valid;
    logic                req_ready;
    logic [31:0]         addr;
    logic                we;
    logic [VMEM_W/8-1:0] be;
    logic [VMEM_W-1:0]   wdata;
    logic [LSU_ID_W-1:0] id;

    // response channel
    logic                rsp_valid;
    logic [LSU_ID_W-1:0] rsp_id;
    logic [VMEM_W-1:0]   rdata;
    logic                err;

    modport req (
        output req_valid, addr, we, be, wdata, id,
        input  req_ready
    );

    modport rsp (
        input rsp_valid, rsp_id, rdata, err
    );

endinterface

// ==== lsu/lsu_fifo.sv ====
//////////////////////////////////////////////////
// circular buffer where push and pop may share a cycle when full
//////////////////////////////////////////////////

module lsu_fifo #(
    parameter int unsigned WIDTH = 8,
    parameter int unsigned DEPTH = 4
) (
    input  logic             clk_i,
    input  logic             async_rst_ni,

    input  logic             push_valid_i,
    output logic             push_ready_o,
    input  logic [WIDTH-1:0] push_data_i,

    output logic             pop_valid_o,
    input  logic             pop_ready_i,
    output logic [WIDTH-1:0] pop_data_o,

    output logic             full_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] buf_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             push_fire, pop_fire;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o       = (count_q == (PTR_W + 1)'(DEPTH));
    assign pop_valid_o  = (count_q != '0);
    assign pop_data_o   = buf_q[rd_ptr_q];
    assign push_ready_o = ~full_o | pop_ready_i;

    assign push_fire = push_valid_i & push_ready_o;
    assign pop_fire  = pop_valid_o & pop_ready_i;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop_fire) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({push_fire, pop_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_fire) begin
            buf_q[wr_ptr_q] <= push_data_i;
        end
    end

    // the producer honours push_ready_o
    no_overflow_a: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        push_valid_i |-> push_ready_o);

    // count stays in range and matches the distance between the pointers
    no_underflow_a: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        count_q <= (PTR_W + 1)'(DEPTH)
            && wr_ptr_q == PTR_W'((int'(rd_ptr_q) + int'(count_q)) % DEPTH));

endmodule

// ==== lsu/lsu_req_stage.sv ====
//////////////////////////////////////////////////
// xval is the base on a first beat, the stride on later strided beats
// issue waits while the completion queue is full
//////////////////////////////////////////////////

module lsu_req_stage import lsu_pkg::*; #(
    parameter  int unsigned VMEM_W = 32,
    localparam int unsigned OFF_W  = $clog2(VMEM_W / 8),
    localparam int unsigned BEAT_W = LSU_BEAT_FIX_W + OFF_W,
    localparam int unsigned PEND_W = OFF_W + VMEM_W / 8 + BEAT_W
) (
    input  logic                clk_i,
    input  logic                async_rst_ni,

    input  logic                in_valid_i,
    output logic                in_ready_o,
    input  logic [BEAT_W-1:0]   in_beat_i,
    input  logic [31:0]         in_xval_i,
    input  logic [31:0]         in_index_i,
    input  logic [VMEM_W-1:0]   in_wdata_i,
    input  logic [VMEM_W/8-1:0] in_mask_i,

    input  logic                cmpl_full_i,

    lsu_mem_if.req              mem,

    output logic                enq_valid_o,
    input  logic                enq_ready_i,
    output logic [PEND_W-1:0]   enq_data_o
);

    localparam int unsigned NB = VMEM_W / 8;

    typedef struct packed {
        logic                first;
        logic                last;
        logic [LSU_ID_W-1:0] id;
        lsu_stride_e         stride;
        lsu_eew_e            eew;
        logic                store;
        logic                masked;
        logic [OFF_W-1:0]    vl_part;
        logic                vl_zero;
    } lsu_beat_t;

    lsu_beat_t         in_beat, beat_q;
    logic              valid_q, hold_q;
    logic              in_fire, issue_ok;
    logic [31:0]       addr_d, addr_q;
    logic [OFF_W-1:0]  off_d;
    logic [VMEM_W-1:0] wdata_d, wdata_q;
    logic [NB-1:0]     be_d, be_q, mask_q;
    logic [NB-1:0]     vl_mask;
    logic              elem_en;

    assign in_beat = in_beat_i;
    assign in_fire = in_valid_i & in_ready_o;

    //////////////////////////////////////////////////
    // address generation

    always_comb begin
        addr_d = addr_q;
        case (in_beat.stride)
            LSU_UNIT_STRIDE: addr_d = in_beat.first ? in_xval_i : addr_q + 32'(NB);
            LSU_STRIDED:     addr_d = in_beat.first ? in_xval_i : addr_q + in_xval_i;
            LSU_INDEXED: begin
                // index scaled by the element bytes
                case (in_beat.eew)
                    LSU_EEW_16: addr_d = in_xval_i + {in_index_i[30:0], 1'b0};
                    LSU_EEW_32: addr_d = in_xval_i + {in_index_i[29:0], 2'b00};
                    default:    addr_d = in_xval_i + in_index_i;
                endcase
            end
            default: ;
        endcase
    end

    assign off_d = addr_d[OFF_W-1:0];

    //////////////////////////////////////////////////
    // store data and byte enables

    // bytes 0 to vl_part of the word
    assign vl_mask = in_beat.vl_zero ? '0 : ({NB{1'b1}} >> ~in_beat.vl_part);
    assign elem_en = ~in_beat.vl_zero & (~in_beat.masked | in_mask_i[0]);

    always_comb begin
        wdata_d = in_wdata_i;
        be_d    = (in_beat.masked ? in_mask_i : {NB{1'b1}}) & vl_mask;
        if (in_beat.stride != LSU_UNIT_STRIDE) begin
            // single element, copied to every lane of its size
            case (in_beat.eew)
                LSU_EEW_16: begin
                    for (int i = 0; i < VMEM_W / 16; i++) begin
                        wdata_d[i*16 +: 16] = in_wdata_i[15:0];
                    end
                    be_d = NB'({2{elem_en}}) << (off_d & ~OFF_W'(1));
                end
                LSU_EEW_32: begin
                    for (int i = 0; i < VMEM_W / 32; i++) begin
                        wdata_d[i*32 +: 32] = in_wdata_i[31:0];
                    end
                    be_d = NB'({4{elem_en}}) << (off_d & ~OFF_W'(3));
                end
                default: begin
                    for (int i = 0; i < NB; i++) begin
                        wdata_d[i*8 +: 8] = in_wdata_i[7:0];
                    end
                    be_d = NB'(elem_en) << off_d;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // request register

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
            hold_q  <= 1'b0;
        end else begin
            if (in_ready_o) begin
                valid_q <= in_valid_i;
            end
            // once raised, a request stays up until it is taken
            hold_q <= mem.req_valid & ~mem.req_ready;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_fire) begin
            beat_q  <= in_beat;
            addr_q  <= addr_d;
            wdata_q <= wdata_d;
            be_q    <= be_d;
            mask_q  <= in_mask_i;
        end
    end

    assign issue_ok = enq_ready_i & ~cmpl_full_i;

    // beats without valid elements skip memory
    assign mem.req_valid = valid_q & ~beat_q.vl_zero & (issue_ok | hold_q);
    assign mem.addr      = {addr_q[31:OFF_W], {OFF_W{1'b0}}};
    assign mem.we        = beat_q.store;
    assign mem.be        = be_q;
    assign mem.wdata     = wdata_q;
    assign mem.id        = beat_q.id;

    assign enq_valid_o = valid_q & (beat_q.vl_zero ? issue_ok : mem.req_valid & mem.req_ready);
    assign enq_data_o  = {addr_q[OFF_W-1:0], mask_q, beat_q};
    assign in_ready_o  = ~valid_q | (enq_valid_o & enq_ready_i);

    req_stable_a: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        mem.req_valid && !mem.req_ready |=> mem.req_valid && $stable(mem.addr)
            && $stable(mem.we) && $stable(mem.be) && $stable(mem.wdata) && $stable(mem.id));

endmodule

// ==== lsu/lsu_rdata_stage.sv ====
//////////////////////////////////////////////////
// a last beat is held while the completion queue is full
// non unit-stride results carry the element in the low bits
//////////////////////////////////////////////////

module lsu_rdata_stage import lsu_pkg::*; #(
    parameter  int unsigned VMEM_W = 32,
    localparam int unsigned OFF_W  = $clog2(VMEM_W / 8),
    localparam int unsigned BEAT_W = LSU_BEAT_FIX_W + OFF_W,
    localparam int unsigned PEND_W = OFF_W + VMEM_W / 8 + BEAT_W,
    localparam int unsigned CMPL_W = LSU_ID_W + 1 + LSU_EXC_W
) (
    input  logic                clk_i,
    input  logic                async_rst_ni,

    input  logic                deq_valid_i,
    output logic                deq_ready_o,
    input  logic [PEND_W-1:0]   deq_data_i,

    lsu_mem_if.rsp              mem,

    output logic                cmpl_valid_o,
    input  logic                cmpl_ready_i,
    output logic [CMPL_W-1:0]   cmpl_data_o,

    output logic                res_valid_o,
    output logic                res_write_o,
    output logic [VMEM_W-1:0]   res_data_o,
    output logic [VMEM_W/8-1:0] res_mask_o,
    output logic [LSU_ID_W-1:0] res_id_o
);

    localparam int unsigned NB = VMEM_W / 8;

    typedef struct packed {
        logic                first;
        logic                last;
        logic [LSU_ID_W-1:0] id;
        lsu_stride_e         stride;
        lsu_eew_e            eew;
        logic                store;
        logic                masked;
        logic [OFF_W-1:0]    vl_part;
        logic                vl_zero;
    } lsu_beat_t;

    lsu_beat_t            beat;
    logic [OFF_W-1:0]     off, elem_off;
    logic [NB-1:0]        mask, vl_mask, mask_d;
    logic                 elem_en;
    logic                 rsp_match, deq_fire;
    logic                 err_d, err_q;
    logic [LSU_EXC_W-1:0] code;
    logic [VMEM_W-1:0]    data_d;

    assign {off, mask, beat} = deq_data_i;

    //////////////////////////////////////////////////
    // dequeue and error tracking

    assign rsp_match   = mem.rsp_valid & (mem.rsp_id == beat.id);
    assign deq_ready_o = (rsp_match | beat.vl_zero) & (~beat.last | cmpl_ready_i);
    assign deq_fire    = deq_valid_i & deq_ready_o;

    // sticky across the beats of one instruction
    assign err_d = (~beat.first & err_q) | (rsp_match & ~beat.vl_zero & mem.err);
    assign code  = beat.store ? EXC_STORE_FAULT : EXC_LOAD_FAULT;

    assign cmpl_valid_o = deq_fire & beat.last;
    assign cmpl_data_o  = {beat.id, err_d, code};

    //////////////////////////////////////////////////
    // load data extraction

    assign vl_mask = beat.vl_zero ? '0 : ({NB{1'b1}} >> ~beat.vl_part);
    assign elem_en = ~beat.vl_zero & (~beat.masked | mask[0]);

    always_comb begin
        case (beat.eew)
            LSU_EEW_16: elem_off = off & ~OFF_W'(1);
            LSU_EEW_32: elem_off = off & ~OFF_W'(3);
            default:    elem_off = off;
        endcase
    end

    always_comb begin
        data_d = mem.rdata;
        mask_d = (beat.masked ? mask : {NB{1'b1}}) & vl_mask;
        if (beat.stride != LSU_UNIT_STRIDE) begin
            data_d = '0;
            mask_d = {NB{elem_en}};
            case (beat.eew)
                LSU_EEW_16: data_d[15:0] = mem.rdata[{elem_off, 3'b000} +: 16];
                LSU_EEW_32: data_d[31:0] = mem.rdata[{elem_off, 3'b000} +: 32];
                default:    data_d[7:0]  = mem.rdata[{elem_off, 3'b000} +: 8];
            endcase
        end
    end

    //////////////////////////////////////////////////
    // result register

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            res_valid_o <= 1'b0;
            err_q       <= 1'b0;
        end else begin
            res_valid_o <= deq_fire;
            if (deq_fire) begin
                err_q <= err_d;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (deq_fire) begin
            res_write_o <= ~beat.store & ~err_d;
            res_data_o  <= data_d;
            res_mask_o  <= mask_d;
            res_id_o    <= beat.id;
        end
    end

    // memory only answers beats already in the pending queue
    rsp_pending_a: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        mem.rsp_valid |-> deq_valid_i);

endmodule

// ==== hdl/vector_lsu.sv ====
//////////////////////////////////////////////////
// VMEM_W is 32 or 64, all addresses word aligned
// the completion queue holds two entries
//////////////////////////////////////////////////

module vector_lsu import lsu_pkg::*; #(
    parameter  int unsigned VMEM_W      = 32,
    parameter  int unsigned QUEUE_DEPTH = 4,
    localparam int unsigned OFF_W       = $clog2(VMEM_W / 8)
) (
    input  logic                 clk_i,
    input  logic                 async_rst_ni,

    // beat from the issue pipeline
    input  logic                 in_valid_i,
    output logic                 in_ready_o,
    input  logic                 in_first_i,
    input  logic                 in_last_i,
    input  logic [LSU_ID_W-1:0]  in_id_i,
    input  lsu_stride_e          in_stride_i,
    input  lsu_eew_e             in_eew_i,
    input  logic                 in_store_i,
    input  logic                 in_masked_i,
    input  logic [OFF_W-1:0]     in_vl_part_i,
    input  logic                 in_vl_zero_i,
    input  logic [31:0]          in_xval_i,
    input  logic [31:0]          in_index_i,
    input  logic [VMEM_W-1:0]    in_wdata_i,
    input  logic [VMEM_W/8-1:0]  in_mask_i,

    // memory
    output logic                 mem_req_valid_o,
    input  logic                 mem_req_ready_i,
    output logic [31:0]          mem_req_addr_o,
    output logic                 mem_req_we_o,
    output logic [VMEM_W/8-1:0]  mem_req_be_o,
    output logic [VMEM_W-1:0]    mem_req_wdata_o,
    output logic [LSU_ID_W-1:0]  mem_req_id_o,
    input  logic                 mem_rsp_valid_i,
    input  logic [LSU_ID_W-1:0]  mem_rsp_id_i,
    input  logic [VMEM_W-1:0]    mem_rsp_rdata_i,
    input  logic                 mem_rsp_err_i,

    // results
    output logic                 res_valid_o,
    output logic                 res_write_o,
    output logic [VMEM_W-1:0]    res_data_o,
    output logic [VMEM_W/8-1:0]  res_mask_o,
    output logic [LSU_ID_W-1:0]  res_id_o,

    // completions
    output logic                 cmpl_valid_o,
    input  logic                 cmpl_ready_i,
    output logic [LSU_ID_W-1:0]  cmpl_id_o,
    output logic                 cmpl_exc_o,
    output logic [LSU_EXC_W-1:0] cmpl_code_o
);

    localparam int unsigned BEAT_W = LSU_BEAT_FIX_W + OFF_W;
    localparam int unsigned PEND_W = OFF_W + VMEM_W / 8 + BEAT_W;
    localparam int unsigned CMPL_W = LSU_ID_W + 1 + LSU_EXC_W;

    logic [BEAT_W-1:0] in_beat;
    logic              enq_valid, enq_ready, deq_valid, deq_ready;
    logic [PEND_W-1:0] enq_data, deq_data;
    logic              cmpl_push_valid, cmpl_push_ready, cmpl_full;
    logic [CMPL_W-1:0] cmpl_push_data, cmpl_pop_data;

    lsu_mem_if #(.VMEM_W(VMEM_W)) mem_if ();

    // field order of the beat struct in the stages
    assign in_beat = {in_first_i, in_last_i, in_id_i, in_stride_i, in_eew_i,
                      in_store_i, in_masked_i, in_vl_part_i, in_vl_zero_i};

    assign mem_req_valid_o  = mem_if.req_valid;
    assign mem_req_addr_o   = mem_if.addr;
    assign mem_req_we_o     = mem_if.we;
    assign mem_req_be_o     = mem_if.be;
    assign mem_req_wdata_o  = mem_if.wdata;
    assign mem_req_id_o     = mem_if.id;
    assign mem_if.req_ready = mem_req_ready_i;
    assign mem_if.rsp_valid = mem_rsp_valid_i;
    assign mem_if.rsp_id    = mem_rsp_id_i;
    assign mem_if.rdata     = mem_rsp_rdata_i;
    assign mem_if.err       = mem_rsp_err_i;

    assign {cmpl_id_o, cmpl_exc_o, cmpl_code_o} = cmpl_pop_data;

    lsu_req_stage #(.VMEM_W(VMEM_W)) req_stage (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .in_beat_i    (in_beat),
        .in_xval_i    (in_xval_i),
        .in_index_i   (in_index_i),
        .in_wdata_i   (in_wdata_i),
        .in_mask_i    (in_mask_i),
        .cmpl_full_i  (cmpl_full),
        .mem          (mem_if.req),
        .enq_valid_o  (enq_valid),
        .enq_ready_i  (enq_ready),
        .enq_data_o   (enq_data)
    );

    lsu_fifo #(.WIDTH(PEND_W), .DEPTH(QUEUE_DEPTH)) pend_queue (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .push_valid_i (enq_valid),
        .push_ready_o (enq_ready),
        .push_data_i  (enq_data),
        .pop_valid_o  (deq_valid),
        .pop_ready_i  (deq_ready),
        .pop_data_o   (deq_data),
        .full_o       ()
    );

    lsu_rdata_stage #(.VMEM_W(VMEM_W)) rdata_stage (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .deq_valid_i  (deq_valid),
        .deq_ready_o  (deq_ready),
        .deq_data_i   (deq_data),
        .mem          (mem_if.rsp),
        .cmpl_valid_o (cmpl_push_valid),
        .cmpl_ready_i (cmpl_push_ready),
        .cmpl_data_o  (cmpl_push_data),
        .res_valid_o  (res_valid_o),
        .res_write_o  (res_write_o),
        .res_data_o   (res_data_o),
        .res_mask_o   (res_mask_o),
        .res_id_o     (res_id_o)
    );

    lsu_fifo #(.WIDTH(CMPL_W), .DEPTH(2)) cmpl_queue (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .push_valid_i (cmpl_push_valid),
        .push_ready_o (cmpl_push_ready),
        .push_data_i  (cmpl_push_data),
        .pop_valid_o  (cmpl_valid_o),
        .pop_ready_i  (cmpl_ready_i),
        .pop_data_o   (cmpl_pop_data),
        .full_o       (cmpl_full)
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
//////////////////////////////////////////////////
// clock with period 8, reset low for the first 5 cycles
//////////////////////////////////////////////////

module tb_clock_gen #(
    parameter int unsigned RST_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o  = 1'b0;
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_no <= 1'b1;
    end

    always #4 clk_o = ~clk_o;

endmodule

// ==== tb/tb_vector_lsu.sv ====
//////////////////////////////////////////////////
// one instruction in flight at a time and memory answers in order
// bus errors for the window 0x300 to 0x33f
//////////////////////////////////////////////////

module tb_vector_lsu import lsu_pkg::*;;

    localparam int unsigned VMEM_W = 64;
    localparam int unsigned NB     = VMEM_W / 8;

    typedef struct packed {
        logic [31:0]         addr;
        logic [NB-1:0]       be;
        logic                we;
        logic [LSU_ID_W-1:0] id;
    } req_t;

    typedef struct packed {
        logic                write;
        logic [VMEM_W-1:0]   data;
        logic [NB-1:0]       mask;
        logic [LSU_ID_W-1:0] id;
    } res_t;

    typedef struct packed {
        logic [LSU_ID_W-1:0]  id;
        logic                 exc;
        logic [LSU_EXC_W-1:0] code;
    } cmpl_t;

    typedef struct packed {
        logic [LSU_ID_W-1:0] id;
        logic [VMEM_W-1:0]   rdata;
        logic                err;
    } rsp_t;

    logic clk_i, async_rst_ni;
    logic in_valid_i, in_ready_o, in_first_i, in_last_i, in_store_i, in_masked_i;
    logic [LSU_ID_W-1:0] in_id_i;
    lsu_stride_e in_stride_i;
    lsu_eew_e in_eew_i;
    logic [2:0] in_vl_part_i;
    logic in_vl_zero_i;
    logic [31:0] in_xval_i, in_index_i;
    logic [VMEM_W-1:0] in_wdata_i;
    logic [NB-1:0] in_mask_i;
    logic mem_req_valid_o, mem_req_ready_i, mem_req_we_o;
    logic [31:0] mem_req_addr_o;
    logic [NB-1:0] mem_req_be_o;
    logic [VMEM_W-1:0] mem_req_wdata_o, mem_rsp_rdata_i, res_data_o;
    logic [LSU_ID_W-1:0] mem_req_id_o, mem_rsp_id_i, res_id_o, cmpl_id_o;
    logic mem_rsp_valid_i, mem_rsp_err_i, res_valid_o, res_write_o;
    logic [NB-1:0] res_mask_o;
    logic cmpl_valid_o, cmpl_ready_i, cmpl_exc_o;
    logic [LSU_EXC_W-1:0] cmpl_code_o;

    logic [7:0] mem [1024];
    logic [7:0] ref_mem [1024];
    req_t  exp_req [$];
    res_t  exp_res [$];
    cmpl_t exp_cmpl [$];
    rsp_t  mem_pipe [$];
    int    wait_cnt, cycles, beats_issued, instr_cnt, cmpl_seen;
    string test_name;

    tb_clock_gen clock_gen (.clk_o(clk_i), .rst_no(async_rst_ni));

    vector_lsu #(.VMEM_W(VMEM_W), .QUEUE_DEPTH(4)) vector_lsu_inst (.*);

    task automatic fail_with(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    function automatic bit in_err_win(input logic [31:0] addr);
        return addr >= 32'h300 && addr < 32'h340;
    endfunction

    //////////////////////////////////////////////////
    // memory model sampling requests between edges

    always @(negedge clk_i) begin
        req_t  rq;
        rsp_t  rs;
        res_t  er;
        cmpl_t ec;
        if (async_rst_ni && mem_req_valid_o && mem_req_ready_i) begin
            if (exp_req.size() == 0) fail_with("memory request with none expected");
            rq = exp_req.pop_front();
            check_eq("req addr", rq.addr, mem_req_addr_o);
            check_eq("req be", rq.be, mem_req_be_o);
            check_eq("req we", rq.we, mem_req_we_o);
            check_eq("req id", rq.id, mem_req_id_o);
            rs.id  = mem_req_id_o;
            rs.err = in_err_win(mem_req_addr_o);
            for (int i = 0; i < NB; i++) begin
                rs.rdata[i*8 +: 8] = mem[mem_req_addr_o[9:0] + i];
                if (mem_req_we_o && !rs.err && mem_req_be_o[i]) begin
                    mem[mem_req_addr_o[9:0] + i] = mem_req_wdata_o[i*8 +: 8];
                end
            end
            mem_pipe.push_back(rs);
        end
        if (async_rst_ni && res_valid_o) begin
            if (exp_res.size() == 0) fail_with("result with none expected");
            er = exp_res.pop_front();
            check_eq("res id", er.id, res_id_o);
            check_eq("res mask", er.mask, res_mask_o);
            check_eq("res write", er.write, res_write_o);
            if (er.write && er.mask != '0) check_eq("res data", er.data, res_data_o);
        end
        if (async_rst_ni && cmpl_valid_o && cmpl_ready_i) begin
            if (exp_cmpl.size() == 0) fail_with("completion with none expected");
            ec = exp_cmpl.pop_front();
            check_eq("cmpl id", ec.id, cmpl_id_o);
            check_eq("cmpl exc", ec.exc, cmpl_exc_o);
            check_eq("cmpl code", ec.code, cmpl_code_o);
            cmpl_seen++;
        end
    end

    // in-order responses after 0 to 4 cycles
    always @(posedge clk_i) begin
        mem_rsp_valid_i <= 1'b0;
        mem_req_ready_i <= ($urandom % 4) != 0;
        cmpl_ready_i    <= ($urandom % 4) != 0;
        if (mem_pipe.size() != 0) begin
            if (wait_cnt == 0) begin
                mem_rsp_valid_i <= 1'b1;
                mem_rsp_id_i    <= mem_pipe[0].id;
                mem_rsp_rdata_i <= mem_pipe[0].rdata;
                mem_rsp_err_i   <= mem_pipe[0].err;
                void'(mem_pipe.pop_front());
                wait_cnt = $urandom % 5;
            end else begin
                wait_cnt--;
            end
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > 40 * beats_issued + 1000) fail_with("timeout, the DUT stopped making progress");
    end

    //////////////////////////////////////////////////
    // stimulus and reference model

    task automatic send_beat(input logic first, last, vlz, input logic [2:0] vp,
                             input logic [31:0] xval, idx, input logic [63:0] wd,
                             input logic [7:0] mk);
        @(posedge clk_i);
        in_valid_i   <= 1'b1;
        in_first_i   <= first;
        in_last_i    <= last;
        in_vl_zero_i <= vlz;
        in_vl_part_i <= vp;
        in_xval_i    <= xval;
        in_index_i   <= idx;
        in_wdata_i   <= wd;
        in_mask_i    <= mk;
        beats_issued++;
        @(negedge clk_i);
        while (!in_ready_o) @(negedge clk_i);
    endtask

    task automatic run_instr(input lsu_stride_e st, input lsu_eew_e ew, input bit store,
                             input int nbeats, input logic [31:0] base, stride,
                             input bit masked, vlz);
        int eb, eoff, lane;
        logic [31:0] addr, idx, xval, wa;
        logic [63:0] wd, rdata;
        logic [7:0] mk, vlm, be, rmask;
        logic [2:0] vp;
        bit err_acc, berr, en;
        logic [LSU_ID_W-1:0] id;
        eb = 1 << ew;
        err_acc = 0;
        addr = base;
        id = LSU_ID_W'(instr_cnt);
        @(posedge clk_i);
        in_stride_i <= st;
        in_eew_i    <= ew;
        in_store_i  <= store;
        in_masked_i <= masked;
        in_id_i     <= id;
        for (int b = 0; b < nbeats; b++) begin
            idx = $urandom % 64;
            wd = {$urandom, $urandom};
            mk = $urandom;
            vp = (b == nbeats - 1) ? 3'($urandom) : 3'd7;
            xval = base;
            if (st == LSU_INDEXED) begin
                addr = base + idx * eb;
            end else if (b > 0) begin
                addr = addr + ((st == LSU_UNIT_STRIDE) ? NB : stride);
                if (st == LSU_STRIDED) xval = stride;
            end
            wa = {addr[31:3], 3'b000};
            vlm = vlz ? 8'h00 : (8'hff >> (7 - vp));
            eoff = addr[2:0] & ~(eb - 1);
            en = !vlz && (!masked || mk[0]);
            rdata = '0;
            if (st == LSU_UNIT_STRIDE) begin
                be = (masked ? mk : 8'hff) & vlm;
                rmask = be;
                for (int i = 0; i < NB; i++) rdata[i*8 +: 8] = ref_mem[wa[9:0] + i];
            end else begin
                be = en ? 8'(((1 << eb) - 1) << eoff) : 8'h00;
                rmask = {8{en}};
                for (int i = 0; i < eb; i++) rdata[i*8 +: 8] = ref_mem[wa[9:0] + eoff + i];
            end
            berr = !vlz && in_err_win(wa);
            err_acc |= berr;
            if (store && !berr) begin
                for (int i = 0; i < NB; i++) begin
                    // unit-stride writes the word as given, others repeat one element
                    lane = (st == LSU_UNIT_STRIDE) ? i : i % eb;
                    if (be[i]) ref_mem[wa[9:0] + i] = wd[lane*8 +: 8];
                end
            end
            if (!vlz) exp_req.push_back('{wa, be, store, id});
            exp_res.push_back('{!store && !err_acc, rdata, rmask, id});
            send_beat(b == 0, b == nbeats - 1, vlz, vp, xval, idx, wd, mk);
        end
        // store access fault 7 and load access fault 5
        exp_cmpl.push_back('{id, err_acc, store ? 6'd7 : 6'd5});
        instr_cnt++;
        @(posedge clk_i);
        in_valid_i <= 1'b0;
        while (cmpl_seen < instr_cnt) @(negedge clk_i);
    endtask

    initial begin
        int nb;
        void'($urandom(98571));
        {in_valid_i, in_first_i, in_last_i, in_store_i, in_masked_i, in_vl_zero_i} = '0;
        in_id_i = '0;
        in_stride_i = LSU_UNIT_STRIDE;
        in_eew_i = LSU_EEW_8;
        in_vl_part_i = '0;
        {in_xval_i, in_index_i, in_wdata_i, in_mask_i} = '0;
        {mem_req_ready_i, mem_rsp_valid_i, mem_rsp_err_i, cmpl_ready_i} = '0;
        mem_rsp_id_i = '0;
        mem_rsp_rdata_i = '0;
        {wait_cnt, cycles, beats_issued, instr_cnt, cmpl_seen} = '0;
        for (int a = 0; a < 1024; a++) begin
            mem[a] = 8'(a * 37 + (a >> 8) * 11);
            ref_mem[a] = mem[a];
        end
        wait (async_rst_ni);

        test_name = "unit_load";
        run_instr(LSU_UNIT_STRIDE, LSU_EEW_32, 0, 5, 32'h040, 0, 1, 0);
        test_name = "strided_store";
        run_instr(LSU_STRIDED, LSU_EEW_8, 1, 4, 32'h101, 3, 0, 0);
        run_instr(LSU_STRIDED, LSU_EEW_16, 1, 4, 32'h142, 6, 1, 0);
        run_instr(LSU_STRIDED, LSU_EEW_32, 1, 4, 32'h184, 12, 0, 0);
        test_name = "indexed_load";
        run_instr(LSU_INDEXED, LSU_EEW_16, 0, 4, 32'h0a0, 0, 1, 0);
        run_instr(LSU_INDEXED, LSU_EEW_32, 0, 3, 32'h120, 0, 0, 0);
        test_name = "vl_zero";
        run_instr(LSU_UNIT_STRIDE, LSU_EEW_8, 0, 1, 32'h080, 0, 0, 1);
        test_name = "bus_error";
        run_instr(LSU_UNIT_STRIDE, LSU_EEW_32, 0, 3, 32'h2f8, 0, 0, 0);
        run_instr(LSU_STRIDED, LSU_EEW_32, 1, 2, 32'h320, 4, 0, 0);
        run_instr(LSU_UNIT_STRIDE, LSU_EEW_32, 0, 2, 32'h200, 0, 0, 0);

        test_name = "random_mix";
        repeat (24) begin
            nb = 1 + $urandom % 4;
            run_instr(lsu_stride_e'($urandom % 3), lsu_eew_e'($urandom % 3), $urandom % 2, nb,
                      32'(($urandom % 64) * 8 + ($urandom % 2) * 4), 32'(($urandom % 8) * 4),
                      $urandom % 2, nb == 1 && ($urandom % 3) == 0);
        end

        test_name = "memory_image";
        for (int a = 0; a < 1024; a++) check_eq("byte", ref_mem[a], mem[a]);
        if (exp_req.size() != 0 || exp_res.size() != 0 || exp_cmpl.size() != 0) begin
            $display("expected requests, results or completions never arrived");
            $display("Test failed");
            $fatal(1);
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// ==== build.f ====
common/lsu_pkg.sv
common/lsu_mem_if.sv
lsu/lsu_fifo.sv
lsu/lsu_req_stage.sv
lsu/lsu_rdata_stage.sv
hdl/vector_lsu.sv
tb/tb_clock_gen.sv
tb/tb_vector_lsu.sv

// ==== Makefile ====
TOP = tb_vector_lsu

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Test passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean
